//--- Makefile
# Verilator build and run for the hwce output stage

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= hwce_engine_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TEST RESULT: PASS

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the pass line in the simulator output
run: compile
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- logic/hwce_cfg.svh
/*
 * hwce output stage configuration
 * widths, counts, fixed-point position and pipeline depths
 */

`ifndef HWCE_CFG_SVH
`define HWCE_CFG_SVH

`define HWCE_CONV_WIDTH 16   // pixel, weight and result
`define HWCE_NPX        2    // output pixels per strobe
`define HWCE_N_COL      4    // filter columns
`define HWCE_N_ROW      3    // taps per column
`define HWCE_WIN_COLS   (`HWCE_N_COL + `HWCE_NPX - 1)
`define HWCE_QF         13   // fraction bits

// column sum holds three full products plus growth
`define HWCE_MUL_WIDTH  (2 * `HWCE_CONV_WIDTH + 2)
`define HWCE_SUM_WIDTH  37   // shift-adder accumulator
`define HWCE_SOP_LAT    1    // column register stage
`define HWCE_SA_PIPE    1    // shift-adder input stage
`define HWCE_CTRL_ADDR  12   // control word slot

`endif

//--- logic/hwce_engine_top.sv
/*
 * hwce engine output stage
 * weight store, four column units and the shift adder
 */

`timescale 1ns/1ns

`include "hwce_cfg.svh"

module hwce_engine_top
   import hwce_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,

   // configuration port
   input  logic       cfg_we_i,
   input  logic [3:0] cfg_addr_i,
   input  cfg_word_u  cfg_wdata_i,

   // data in sampled together
   input  logic       win_valid_i,
   input  window_t    win_i,
   input  px_vec_t    partial_i,

   // result two cycles after the strobe
   output logic       out_valid_o,
   output px_vec_t    out_o
);

   filter_t                        filter;
   sa_ctrl_t                       sa_ctrl;
   col_sum_t [`HWCE_N_COL-1:0]     col_sum;
   logic     [`HWCE_N_COL-1:0]     col_valid;

   hwce_weight_store hwce_weight_store_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .cfg_we_i    (cfg_we_i),
      .cfg_addr_i  (cfg_addr_i),
      .cfg_wdata_i (cfg_wdata_i),
      .filter_o    (filter),
      .ctrl_o      (sa_ctrl)
   );

   for (genvar c = 0; c < `HWCE_N_COL; c++) begin : g_col
      hwce_sop_column #(
         .COL_IDX (c)
      ) hwce_sop_column_i (
         .clk       (clk),
         .rst_n     (rst_n),
         .valid_i   (win_valid_i),
         .win_i     (win_i),
         .weights_i (filter[c]),
         .sum_o     (col_sum[c]),
         .valid_o   (col_valid[c])
      );
   end

   hwce_shift_adder #(
      .PIPE_STAGES (`HWCE_SA_PIPE)
   ) hwce_shift_adder_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .y_i         (partial_i),     // raw partial delayed inside
      .valid_y_i   (win_valid_i),
      .sop_i       (col_sum),
      .valid_sop_i (col_valid),
      .ctrl_i      (sa_ctrl),
      .y_o         (out_o),
      .valid_y_o   (out_valid_o)
   );

endmodule

//--- logic/hwce_pkg.sv
/*
 * hwce shared types
 * pixel vectors, window and filter layouts, column sums, control
 * and the two views of a configuration word
 */

`include "hwce_cfg.svh"

package hwce_pkg;

   typedef logic signed [`HWCE_CONV_WIDTH-1:0] pixel_t;
   typedef logic signed [`HWCE_MUL_WIDTH-1:0]  mul_t;   // one column sum

   typedef struct packed {
      pixel_t [`HWCE_N_ROW-1:0][`HWCE_WIN_COLS-1:0] px;   // [row][col]
   } window_t;

   typedef pixel_t       [`HWCE_NPX-1:0]   px_vec_t;
   typedef pixel_t       [`HWCE_N_ROW-1:0] col_weights_t;   // indexed by row
   typedef col_weights_t [`HWCE_N_COL-1:0] filter_t;

   typedef struct packed {
      mul_t [`HWCE_NPX-1:0] sum;   // one per output pixel
   } col_sum_t;

   typedef struct packed {
      pixel_t bias;
      logic   use_bias;
      logic   relu;
   } sa_ctrl_t;

   // same 32-bit bus word, decoded by target address
   typedef union packed {
      struct packed {
         logic [15:0] unused;
         pixel_t      weight;
      } wgt;
      struct packed {
         logic [13:0] unused;
         logic        relu;
         logic        use_bias;
         pixel_t      bias;
      } ctrl;
   } cfg_word_u;

endpackage

//--- logic/hwce_shift_adder.sv
/*
 * hwce shift adder
 * aligns partial or bias to Q13, adds the column sums,
 * scales back, saturates to 16 bits, optional relu
 */

`timescale 1ns/1ns

`include "hwce_cfg.svh"

module hwce_shift_adder
   import hwce_pkg::*;
#(
   parameter int PIPE_STAGES = `HWCE_SA_PIPE
)
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  px_vec_t                     y_i,
   input  logic                        valid_y_i,
   input  col_sum_t [`HWCE_N_COL-1:0]  sop_i,
   input  logic     [`HWCE_N_COL-1:0]  valid_sop_i,
   input  sa_ctrl_t                    ctrl_i,
   output px_vec_t                     y_o,
   output logic                        valid_y_o
);

   localparam int NPX    = `HWCE_NPX;
   localparam int N_COL  = `HWCE_N_COL;
   localparam int CONV_W = `HWCE_CONV_WIDTH;
   localparam int SUM_W  = `HWCE_SUM_WIDTH;
   localparam int Y_DLY  = `HWCE_SOP_LAT + PIPE_STAGES;   // partial skips the columns

   px_vec_t                    y_d;
   logic                       valid_y_d;
   col_sum_t [N_COL-1:0]       sop_d;
   logic     [N_COL-1:0]       valid_sop_d;

   logic signed [SUM_W-1:0]    base  [NPX];
   logic signed [SUM_W-1:0]    total [NPX];
   logic signed [SUM_W-1:0]    shifted [NPX];
   px_vec_t                    sat;

   generate
      if (Y_DLY > 0) begin : g_y_pipe
         px_vec_t [Y_DLY-1:0] y_q;
         logic    [Y_DLY-1:0] vy_q;

         always_ff @(posedge clk) begin
            y_q[0] <= y_i;
            for (int k = 1; k < Y_DLY; k++) begin
               y_q[k] <= y_q[k-1];
            end
         end

         always_ff @(posedge clk) begin
            if (!rst_n) begin
               vy_q <= '0;
            end else begin
               vy_q[0] <= valid_y_i;
               for (int k = 1; k < Y_DLY; k++) begin
                  vy_q[k] <= vy_q[k-1];
               end
            end
         end

         assign y_d       = y_q[Y_DLY-1];
         assign valid_y_d = vy_q[Y_DLY-1];
      end else begin : g_y_direct
         assign y_d       = y_i;
         assign valid_y_d = valid_y_i;
      end

      if (PIPE_STAGES > 0) begin : g_sop_pipe
         col_sum_t [PIPE_STAGES-1:0][N_COL-1:0] sop_q;
         logic     [PIPE_STAGES-1:0][N_COL-1:0] vsop_q;

         always_ff @(posedge clk) begin
            sop_q[0] <= sop_i;
            for (int k = 1; k < PIPE_STAGES; k++) begin
               sop_q[k] <= sop_q[k-1];
            end
         end

         always_ff @(posedge clk) begin
            if (!rst_n) begin
               vsop_q <= '0;
            end else begin
               vsop_q[0] <= valid_sop_i;
               for (int k = 1; k < PIPE_STAGES; k++) begin
                  vsop_q[k] <= vsop_q[k-1];
               end
            end
         end

         assign sop_d       = sop_q[PIPE_STAGES-1];
         assign valid_sop_d = vsop_q[PIPE_STAGES-1];
      end else begin : g_sop_direct
         assign sop_d       = sop_i;
         assign valid_sop_d = valid_sop_i;
      end
   endgenerate

   always_comb begin
      for (int p = 0; p < NPX; p++) begin
         // bias replaces the partial as sign-extended base
         base[p]  = ctrl_i.use_bias ? ctrl_i.bias : y_d[p];
         total[p] = base[p] <<< `HWCE_QF;
         for (int c = 0; c < N_COL; c++) begin
            total[p] = total[p] + sop_d[c].sum[p];
         end
         shifted[p] = total[p] >>> `HWCE_QF;

         // upper bits must all equal the 16-bit sign
         if (&shifted[p][SUM_W-1:CONV_W-1] || ~|shifted[p][SUM_W-1:CONV_W-1]) begin
            sat[p] = shifted[p][CONV_W-1:0];
         end else if (shifted[p][SUM_W-1]) begin
            sat[p] = {1'b1, {(CONV_W-1){1'b0}}};   // 0x8000
         end else begin
            sat[p] = {1'b0, {(CONV_W-1){1'b1}}};   // 0x7fff
         end

         y_o[p] = (ctrl_i.relu && sat[p][CONV_W-1]) ? '0 : sat[p];
      end
   end

   assign valid_y_o = valid_y_d & (&valid_sop_d);

   // partial and column paths must stay lined up
   a_valid_align: assert property (
      @(posedge clk) disable iff (!rst_n)
      valid_sop_d == {N_COL{valid_y_d}}
   ) else $error("partial valid out of step with column valids %b", valid_sop_d);

endmodule

//--- logic/hwce_sop_column.sv
/*
 * hwce column sum of products
 * one filter column against two adjacent window columns,
 * three taps per pixel, registered result
 */

`timescale 1ns/1ns

`include "hwce_cfg.svh"

module hwce_sop_column
   import hwce_pkg::*;
#(
   parameter int COL_IDX = 0   // filter column handled here
)
(
   input  logic         clk,
   input  logic         rst_n,
   input  logic         valid_i,
   input  window_t      win_i,
   input  col_weights_t weights_i,
   output col_sum_t     sum_o,
   output logic         valid_o
);

   localparam int NPX    = `HWCE_NPX;
   localparam int N_ROW  = `HWCE_N_ROW;
   localparam int PROD_W = 2 * `HWCE_CONV_WIDTH;

   // products per pixel and tap
   logic signed [PROD_W-1:0] prod [NPX][N_ROW];
   col_sum_t                 sum_d;

   // pixel p sits one window column further right
   always_comb begin
      for (int p = 0; p < NPX; p++) begin
         for (int r = 0; r < N_ROW; r++) begin
            prod[p][r] = win_i.px[r][COL_IDX + p] * weights_i[r];
         end
      end
   end

   always_comb begin
      for (int p = 0; p < NPX; p++) begin
         sum_d.sum[p] = '0;
         for (int r = 0; r < N_ROW; r++) begin
            sum_d.sum[p] = sum_d.sum[p] + prod[p][r];   // sign-extends to 34 bits
         end
      end
   end

   // payload only moves with a strobe
   always_ff @(posedge clk) begin
      if (valid_i) begin
         sum_o <= sum_d;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_o <= 1'b0;
      end else begin
         valid_o <= valid_i;
      end
   end

   // a window column beyond the edge means a bad COL_IDX
   initial begin
      if (COL_IDX + NPX > `HWCE_WIN_COLS) begin
         $error("COL_IDX %0d reads past the window", COL_IDX);
      end
   end

endmodule

//--- logic/hwce_weight_store.sv
/*
 * hwce weight store
 * holds the 3x4 filter and the shift-adder control word,
 * written one entry at a time over the configuration port
 */

`timescale 1ns/1ns

`include "hwce_cfg.svh"

module hwce_weight_store
   import hwce_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      cfg_we_i,
   input  logic [3:0] cfg_addr_i,
   input  cfg_word_u cfg_wdata_i,
   output filter_t   filter_o,
   output sa_ctrl_t  ctrl_o
);

   localparam int N_COL = `HWCE_N_COL;
   localparam int N_ROW = `HWCE_N_ROW;

   logic ctrl_sel;   // write targets the control slot

   assign ctrl_sel = (cfg_addr_i == 4'(`HWCE_CTRL_ADDR));

   // weight slot address is col*3 + row
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         filter_o <= '0;
      end else if (cfg_we_i) begin
         for (int c = 0; c < N_COL; c++) begin
            for (int r = 0; r < N_ROW; r++) begin
               if (cfg_addr_i == 4'(c * N_ROW + r)) begin
                  filter_o[c][r] <= cfg_wdata_i.wgt.weight;
               end
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ctrl_o <= '0;
      end else if (cfg_we_i && ctrl_sel) begin
         ctrl_o.bias     <= cfg_wdata_i.ctrl.bias;
         ctrl_o.use_bias <= cfg_wdata_i.ctrl.use_bias;   // base from bias instead of partial
         ctrl_o.relu     <= cfg_wdata_i.ctrl.relu;
      end
   end

   // nothing is mapped past the control word
   a_cfg_addr_range: assert property (
      @(posedge clk) disable iff (!rst_n)
      cfg_we_i |-> (cfg_addr_i <= 4'(`HWCE_CTRL_ADDR))
   ) else $error("config write to unmapped address %0d", cfg_addr_i);

endmodule

//--- src.f
+incdir+logic
logic/hwce_pkg.sv
logic/hwce_weight_store.sv
logic/hwce_sop_column.sv
logic/hwce_shift_adder.sv
logic/hwce_engine_top.sv
tb/hwce_engine_tb.sv

//--- tb/hwce_engine_tb.sv
/*
 * hwce engine testbench
 * loads filters and control over the config port, streams random
 * and corner-case windows, checks each result against a model
 */

`timescale 1ns/1ns

`include "hwce_cfg.svh"

module hwce_engine_tb
   import hwce_pkg::*;
;

   localparam pixel_t PX_MAX = 16'sh7fff;
   localparam pixel_t PX_MIN = -16'sh8000;

   logic       clk;
   logic       rst_n;
   logic       cfg_we_i;
   logic [3:0] cfg_addr_i;
   cfg_word_u  cfg_wdata_i;
   logic       win_valid_i;
   window_t    win_i;
   px_vec_t    partial_i;
   logic       out_valid_o;
   px_vec_t    out_o;

   logic [31:0] lfsr = 32'h729d_d2a3;
   filter_t     model_filter;   // what the weight store should hold
   sa_ctrl_t    model_ctrl;
   px_vec_t     exp_q [$];
   px_vec_t     exp_val;
   logic [1:0]  vhist;          // strobe history with [1] two cycles back

   hwce_engine_top hwce_engine_top_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .cfg_we_i    (cfg_we_i),
      .cfg_addr_i  (cfg_addr_i),
      .cfg_wdata_i (cfg_wdata_i),
      .win_valid_i (win_valid_i),
      .win_i       (win_i),
      .partial_i   (partial_i),
      .out_valid_o (out_valid_o),
      .out_o       (out_o)
   );

   always #20 clk = ~clk;

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped on first error");
   endtask

   // taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic pixel_t rand_signed(input int n);
      int x;
      x = int'(rand_bits(n));
      if (x >= (1 << (n - 1))) x = x - (1 << n);   // sign of an n-bit value
      return pixel_t'(x);
   endfunction

   // expected output from the fixed-point rule
   function automatic px_vec_t ref_output(input window_t w, input px_vec_t partial,
                                          input filter_t f, input sa_ctrl_t ctrl);
      longint  total;
      longint  shifted;
      pixel_t  r16;
      px_vec_t res;
      for (int p = 0; p < `HWCE_NPX; p++) begin
         total = (ctrl.use_bias ? longint'(ctrl.bias) : longint'(partial[p]))
                 * (longint'(1) << `HWCE_QF);
         for (int c = 0; c < `HWCE_N_COL; c++) begin
            for (int r = 0; r < `HWCE_N_ROW; r++) begin
               total += longint'(w.px[r][c + p]) * longint'(f[c][r]);
            end
         end
         shifted = total >>> `HWCE_QF;
         if (shifted > 32767) r16 = PX_MAX;
         else if (shifted < -32768) r16 = PX_MIN;
         else r16 = pixel_t'(shifted);
         if (ctrl.relu && r16 < 0) r16 = '0;
         res[p] = r16;
      end
      return res;
   endfunction

   task automatic write_cfg(input logic [3:0] addr, input cfg_word_u w);
      @(posedge clk);
      cfg_we_i    <= 1'b1;
      cfg_addr_i  <= addr;
      cfg_wdata_i <= w;
      @(posedge clk);
      cfg_we_i    <= 1'b0;
   endtask

   task automatic load_weight(input int c, input int r, input pixel_t v);
      cfg_word_u w;
      w = '0;
      w.wgt.weight = v;
      write_cfg(4'(c * `HWCE_N_ROW + r), w);
      model_filter[c][r] = v;
   endtask

   task automatic load_ctrl(input pixel_t bias, input logic use_bias, input logic relu);
      cfg_word_u w;
      w = '0;
      w.ctrl.bias     = bias;
      w.ctrl.use_bias = use_bias;
      w.ctrl.relu     = relu;
      write_cfg(4'(`HWCE_CTRL_ADDR), w);
      model_ctrl = '{bias: bias, use_bias: use_bias, relu: relu};
   endtask

   task automatic load_filter(input int bits, input bit all_max);
      for (int c = 0; c < `HWCE_N_COL; c++) begin
         for (int r = 0; r < `HWCE_N_ROW; r++) begin
            load_weight(c, r, all_max ? PX_MAX : rand_signed(bits));
         end
      end
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         win_valid_i <= 1'b0;
      end
   endtask

   task automatic send_window(input window_t w, input px_vec_t partial);
      @(posedge clk);
      win_valid_i <= 1'b1;
      win_i       <= w;
      partial_i   <= partial;
      exp_q.push_back(ref_output(w, partial, model_filter, model_ctrl));
   endtask

   // random windows sent back to back when gap_bits is 0
   task automatic send_burst(input int count, input int gap_bits, input bit nz_partial);
      window_t w;
      px_vec_t part;
      int      gap;
      for (int i = 0; i < count; i++) begin
         for (int r = 0; r < `HWCE_N_ROW; r++) begin
            for (int c = 0; c < `HWCE_WIN_COLS; c++) w.px[r][c] = rand_signed(12);
         end
         for (int p = 0; p < `HWCE_NPX; p++) begin
            part[p] = rand_signed(12);
            if (nz_partial && part[p] == 0) part[p] = 16'sd1;
         end
         send_window(w, part);
         gap = (gap_bits > 0) ? int'(rand_bits(gap_bits)) : 0;
         if (gap > 0) idle(gap);
      end
      idle(1);
   endtask

   // col 0 only feeds pixel 0, col 4 only pixel 1
   task automatic send_sat_set();
      pixel_t  edge_l [4];
      pixel_t  mid    [4];
      pixel_t  edge_r [4];
      window_t w;
      edge_l = '{PX_MAX, PX_MIN, PX_MAX, PX_MIN};
      mid    = '{PX_MAX, PX_MIN, 16'sd0, 16'sd0};
      edge_r = '{PX_MAX, PX_MIN, PX_MIN, PX_MAX};
      for (int k = 0; k < 4; k++) begin
         for (int r = 0; r < `HWCE_N_ROW; r++) begin
            w.px[r][0] = edge_l[k];
            for (int c = 1; c < `HWCE_WIN_COLS - 1; c++) w.px[r][c] = mid[k];
            w.px[r][`HWCE_WIN_COLS - 1] = edge_r[k];
         end
         send_window(w, '0);
      end
      idle(1);
   endtask

   task automatic wait_drain();
      int t;
      t = 0;
      while (exp_q.size() > 0 && t < 50) begin
         @(posedge clk);
         t++;
      end
      assert (exp_q.size() == 0)
         else stop_on_error("timed out waiting for results of pending windows");
   endtask

   // result check away from the driving edge
   always @(negedge clk) begin
      if (!rst_n) begin
         vhist = 2'b00;
      end else begin
         assert (out_valid_o === vhist[1])
            else stop_on_error($sformatf("FAIL out_valid_o expected 0x%h got 0x%h",
                                         vhist[1], out_valid_o));
         if (out_valid_o === 1'b1) begin
            assert (exp_q.size() > 0)
               else stop_on_error("a result appeared with no window pending");
            exp_val = exp_q.pop_front();
            for (int p = 0; p < `HWCE_NPX; p++) begin
               assert (out_o[p] === exp_val[p])
                  else stop_on_error($sformatf("FAIL out_o[%0d] expected 0x%h got 0x%h",
                                               p, exp_val[p], out_o[p]));
            end
         end
         vhist = {vhist[0], win_valid_i};
      end
   end

   initial begin
      clk          = 1'b0;
      rst_n        = 1'b0;
      cfg_we_i     = 1'b0;
      cfg_addr_i   = '0;
      cfg_wdata_i  = '0;
      win_valid_i  = 1'b0;
      win_i        = '0;
      partial_i    = '0;
      model_filter = '0;
      model_ctrl   = '0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;

      load_filter(12, 0);   // plain partial plus sums
      load_ctrl('0, 1'b0, 1'b0);
      send_burst(20, 0, 0);
      wait_drain();
      load_ctrl(rand_signed(12), 1'b1, 1'b0);   // partial must be ignored
      send_burst(12, 0, 1);
      wait_drain();
      load_filter(0, 1);
      load_ctrl('0, 1'b0, 1'b0);
      send_sat_set();
      wait_drain();
      load_ctrl('0, 1'b0, 1'b1);   // saturated negatives clamp to zero
      send_sat_set();
      wait_drain();
      load_filter(12, 0);
      send_burst(16, 0, 0);
      wait_drain();
      load_ctrl('0, 1'b0, 1'b0);
      send_burst(30, 2, 0);   // gaps of 0 to 3 cycles
      wait_drain();
      repeat (3) begin
         load_filter(10, 0);
         load_ctrl(rand_signed(10), 1'(rand_bits(1)), 1'(rand_bits(1)));
         send_burst(10, 1, 1'(rand_bits(1)));
         wait_drain();
      end
      idle(5);

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule
